/* all.f */
+incdir+include
source/axi2per_pkg.sv
source/axi2per_req_channel.sv
source/axi2per_res_channel.sv
source/axi2per_top.sv
testbench/per_slave_model.sv
testbench/axi2per_tb.sv

/* include/axi2per_settings.svh */
// AXI to peripheral bridge widths

`ifndef AXI2PER_SETTINGS_SVH
`define AXI2PER_SETTINGS_SVH

// AXI slave port
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64
`define AXI_STRB_WIDTH 8
`define AXI_ID_WIDTH 3

// Peripheral bus, one 32-bit word per transfer
`define PER_ADDR_WIDTH 32
`define PER_DATA_WIDTH 32
`define PER_BE_WIDTH 4

// Cluster identification
`define CLUSTER_ID_WIDTH 6

// Address span of one cluster
// Subtracted per cluster id before a request reaches the peripherals
`define CLUSTER_ADDR_STRIDE 32'h0040_0000

`endif

/* run_sim.sh */
#!/bin/sh
# Compile and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module axi2per_tb \
  -Mdir obj_dir -o axi2per_sim

./obj_dir/axi2per_sim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation finished without failures"

/* source/axi2per_pkg.sv */
// AXI to peripheral bridge types

package axi2per_pkg;

  `include "axi2per_settings.svh"

  // AXI vectors
  typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [`AXI_STRB_WIDTH-1:0] axi_strb_t;
  typedef logic [`AXI_ID_WIDTH-1:0]   axi_id_t;
  typedef logic [1:0]                 axi_resp_t;

  // Peripheral vectors
  typedef logic [`PER_ADDR_WIDTH-1:0] per_addr_t;
  typedef logic [`PER_DATA_WIDTH-1:0] per_data_t;
  typedef logic [`PER_BE_WIDTH-1:0]   per_be_t;

  typedef logic [`CLUSTER_ID_WIDTH-1:0] cluster_id_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // AXI channel payloads, single beat only
  typedef struct packed {
    axi_addr_t addr;
    axi_id_t   id;
  } aw_chan_t;

  typedef struct packed {
    axi_addr_t addr;
    axi_id_t   id;
  } ar_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_id_t   id;
    axi_resp_t resp;
    logic      last;
  } r_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_chan_t;

  // Peripheral request, we is active low
  typedef struct packed {
    per_addr_t add;
    logic      we;
    per_data_t wdata;
    per_be_t   be;
  } per_req_t;

  // Peripheral response, opc set means error
  typedef struct packed {
    per_data_t rdata;
    logic      opc;
  } per_resp_t;

  // Outstanding transaction, handed to the response channel
  typedef struct packed {
    logic      we;
    axi_id_t   id;
    axi_addr_t add;
  } trans_t;

  // Request channel states
  typedef enum logic {
    Idle,
    Pending
  } req_state_e;

endpackage

/* source/axi2per_req_channel.sv */
// Bridge request channel

`timescale 1ns/100ps
`include "axi2per_settings.svh"

module axi2per_req_channel
  import axi2per_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  cluster_id_t cluster_id_i,

  // Write address
  input  logic        aw_valid_i,
  input  aw_chan_t    aw_i,
  output logic        aw_ready_o,

  // Read address
  input  logic        ar_valid_i,
  input  ar_chan_t    ar_i,
  output logic        ar_ready_o,

  // Write data
  input  logic        w_valid_i,
  input  w_chan_t     w_i,
  output logic        w_ready_o,

  // Peripheral request
  output logic        per_req_o,
  output per_req_t    per_req_data_o,
  input  logic        per_gnt_i,

  // To and from the response channel
  output logic        trans_valid_o,
  output trans_t      trans_o,
  input  logic        trans_done_i,

  output logic        busy_o
);

  req_state_e state_d, state_q;

  logic       rd_sel;
  logic       wr_sel;
  axi_addr_t  sel_addr;
  per_addr_t  cluster_base;

  // Read wins over a waiting write
  assign rd_sel = (state_q == Idle) && ar_valid_i;
  assign wr_sel = (state_q == Idle) && !ar_valid_i && aw_valid_i && w_valid_i;

  assign sel_addr = rd_sel ? ar_i.addr : aw_i.addr;

  // Base address of this cluster in the global map
  assign cluster_base = per_addr_t'(`CLUSTER_ADDR_STRIDE) * per_addr_t'(cluster_id_i);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (trans_valid_o) begin
          state_d = Pending;
        end
      end
      Pending: begin
        // Response channel has closed the transaction
        if (trans_done_i) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  // Peripheral request payload
  always_comb begin
    per_req_data_o    = '0;
    per_req_data_o.we = 1'b1;
    if (rd_sel) begin
      per_req_data_o.add = sel_addr - cluster_base;
    end else if (wr_sel) begin
      per_req_data_o.add = sel_addr - cluster_base;
      per_req_data_o.we  = 1'b0;
      // Pick the 32-bit lane from address bit 2
      if (aw_i.addr[2]) begin
        per_req_data_o.wdata = w_i.data[63:32];
        per_req_data_o.be    = w_i.strb[7:4];
      end else begin
        per_req_data_o.wdata = w_i.data[31:0];
        per_req_data_o.be    = w_i.strb[3:0];
      end
    end
  end

  assign per_req_o = rd_sel || wr_sel;

  // AXI handshakes complete on the grant cycle
  assign ar_ready_o = rd_sel && per_gnt_i;
  assign aw_ready_o = wr_sel && per_gnt_i;
  assign w_ready_o  = wr_sel && per_gnt_i;

  assign trans_valid_o = per_req_o && per_gnt_i;

  // Record keeps the unmodified AXI address
  always_comb begin
    trans_o     = '0;
    trans_o.we  = rd_sel;
    trans_o.id  = rd_sel ? ar_i.id : aw_i.id;
    trans_o.add = sel_addr;
  end

  assign busy_o = (state_q == Pending);

endmodule

/* source/axi2per_res_channel.sv */
// Bridge response channel

`timescale 1ns/100ps

module axi2per_res_channel
  import axi2per_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Transaction record from the request channel
  input  logic      trans_valid_i,
  input  trans_t    trans_i,

  // Peripheral response, one cycle after the grant
  input  logic      per_r_valid_i,
  input  per_resp_t per_resp_i,

  // Read data
  output logic      r_valid_o,
  output r_chan_t   r_o,
  input  logic      r_ready_i,

  // Write response
  output logic      b_valid_o,
  output b_chan_t   b_o,
  input  logic      b_ready_i,

  // Pulses when the R or B beat has been taken
  output logic      trans_done_o
);

  trans_t    trans_q;
  r_chan_t   r_q;
  b_chan_t   b_q;
  logic      r_valid_q;
  logic      b_valid_q;
  axi_resp_t resp;

  logic      r_hs;
  logic      b_hs;

  assign resp = per_resp_i.opc ? RESP_SLVERR : RESP_OKAY;

  assign r_hs = r_valid_q && r_ready_i;
  assign b_hs = b_valid_q && b_ready_i;

  // Record of the one outstanding transaction
  always_ff @(posedge clk_i) begin
    if (trans_valid_i) begin
      trans_q <= trans_i;
    end
  end

  // Response payloads
  always_ff @(posedge clk_i) begin
    if (per_r_valid_i) begin
      if (trans_q.we) begin
        // Read word goes out on both lanes
        r_q.data <= {per_resp_i.rdata, per_resp_i.rdata};
        r_q.id   <= trans_q.id;
        r_q.resp <= resp;
        r_q.last <= 1'b1;
      end else begin
        b_q.id   <= trans_q.id;
        b_q.resp <= resp;
      end
    end
  end

  // Valid flags, held until the AXI side takes the beat
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (per_r_valid_i && trans_q.we) begin
        r_valid_q <= 1'b1;
      end else if (r_hs) begin
        r_valid_q <= 1'b0;
      end

      if (per_r_valid_i && !trans_q.we) begin
        b_valid_q <= 1'b1;
      end else if (b_hs) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_o       = r_q;
  assign b_valid_o = b_valid_q;
  assign b_o       = b_q;

  // Frees the request channel
  assign trans_done_o = r_hs || b_hs;

endmodule

/* source/axi2per_top.sv */
// AXI to peripheral bridge

`timescale 1ns/100ps

module axi2per_top
  import axi2per_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  cluster_id_t cluster_id_i,

  // AXI write address
  input  logic        aw_valid_i,
  input  aw_chan_t    aw_i,
  output logic        aw_ready_o,

  // AXI read address
  input  logic        ar_valid_i,
  input  ar_chan_t    ar_i,
  output logic        ar_ready_o,

  // AXI write data
  input  logic        w_valid_i,
  input  w_chan_t     w_i,
  output logic        w_ready_o,

  // AXI read data
  output logic        r_valid_o,
  output r_chan_t     r_o,
  input  logic        r_ready_i,

  // AXI write response
  output logic        b_valid_o,
  output b_chan_t     b_o,
  input  logic        b_ready_i,

  // Peripheral bus
  output logic        per_req_o,
  output per_req_t    per_req_data_o,
  input  logic        per_gnt_i,
  input  logic        per_r_valid_i,
  input  per_resp_t   per_resp_i,

  // High while a transaction is outstanding
  output logic        busy_o
);

  logic   trans_valid;
  trans_t trans;
  logic   trans_done;

  axi2per_req_channel i_req_channel (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cluster_id_i   (cluster_id_i),
    .aw_valid_i     (aw_valid_i),
    .aw_i           (aw_i),
    .aw_ready_o     (aw_ready_o),
    .ar_valid_i     (ar_valid_i),
    .ar_i           (ar_i),
    .ar_ready_o     (ar_ready_o),
    .w_valid_i      (w_valid_i),
    .w_i            (w_i),
    .w_ready_o      (w_ready_o),
    .per_req_o      (per_req_o),
    .per_req_data_o (per_req_data_o),
    .per_gnt_i      (per_gnt_i),
    .trans_valid_o  (trans_valid),
    .trans_o        (trans),
    .trans_done_i   (trans_done),
    .busy_o         (busy_o)
  );

  axi2per_res_channel i_res_channel (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .trans_valid_i  (trans_valid),
    .trans_i        (trans),
    .per_r_valid_i  (per_r_valid_i),
    .per_resp_i     (per_resp_i),
    .r_valid_o      (r_valid_o),
    .r_o            (r_o),
    .r_ready_i      (r_ready_i),
    .b_valid_o      (b_valid_o),
    .b_o            (b_o),
    .b_ready_i      (b_ready_i),
    .trans_done_o   (trans_done)
  );

endmodule

/* testbench/axi2per_tb.sv */
// AXI to peripheral bridge testbench

`timescale 1ns/100ps

module axi2per_tb
  import axi2per_pkg::*;
();

  // Cycle bounds of the six tests and of reset
  localparam int TEST_CYCLES = 30 + 40 + 30 + 40 + 40 + 30;
  localparam int RESET_CYCLES = 3;

  logic        clk = 1'b0;
  logic        rst_n;
  cluster_id_t cluster_id;
  logic        aw_valid, aw_ready, ar_valid, ar_ready, w_valid, w_ready;
  logic        r_valid, r_ready, b_valid, b_ready;
  aw_chan_t    aw;
  ar_chan_t    ar;
  w_chan_t     w;
  r_chan_t     r_o;
  b_chan_t     b_o;
  logic        per_req, per_gnt, per_r_valid, busy;
  per_req_t    per_req_data;
  per_resp_t   per_resp;
  int          errors = 0;
  per_addr_t   granted_write_add;

  always #20 clk = ~clk;

  axi2per_top uut (
    .clk_i (clk), .rst_ni (rst_n), .cluster_id_i (cluster_id),
    .aw_valid_i (aw_valid), .aw_i (aw), .aw_ready_o (aw_ready),
    .ar_valid_i (ar_valid), .ar_i (ar), .ar_ready_o (ar_ready),
    .w_valid_i (w_valid), .w_i (w), .w_ready_o (w_ready),
    .r_valid_o (r_valid), .r_o (r_o), .r_ready_i (r_ready),
    .b_valid_o (b_valid), .b_o (b_o), .b_ready_i (b_ready),
    .per_req_o (per_req), .per_req_data_o (per_req_data), .per_gnt_i (per_gnt),
    .per_r_valid_i (per_r_valid), .per_resp_i (per_resp), .busy_o (busy)
  );

  per_slave_model i_per_slave (
    .clk_i (clk), .rst_ni (rst_n), .req_i (per_req), .req_data_i (per_req_data),
    .gnt_o (per_gnt), .r_valid_o (per_r_valid), .resp_o (per_resp)
  );

  task automatic check(input bit ok, input string what);
    assert (ok) else begin
      errors++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  function automatic per_data_t merge_bytes(input per_data_t old_word,
                                            input per_data_t new_word, input per_be_t be);
    per_data_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) merged[8*i +: 8] = new_word[8*i +: 8];
    end
    return merged;
  endfunction

  task automatic drive_write(input axi_addr_t addr, input axi_id_t id, input axi_data_t data,
                             input axi_strb_t strb);
    aw       = '{addr: addr, id: id};
    w        = '{data: data, strb: strb, last: 1'b1};
    aw_valid = 1'b1;
    w_valid  = 1'b1;
  endtask

  task automatic drive_read(input axi_addr_t addr, input axi_id_t id);
    ar       = '{addr: addr, id: id};
    ar_valid = 1'b1;
  endtask

  // Ready is sampled at the falling edge and valids drop after the taking edge
  task automatic wait_write_accept();
    do @(negedge clk); while (!aw_ready);
    check(w_ready, "W ready did not come with AW ready");
    granted_write_add = per_req_data.add;
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
  endtask

  task automatic wait_read_accept();
    do @(negedge clk); while (!ar_ready);
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
  endtask

  task automatic collect_r(output r_chan_t r);
    r_ready = 1'b1;
    do @(negedge clk); while (!r_valid);
    r = r_o;
    @(posedge clk);
    #1;
    r_ready = 1'b0;
  endtask

  task automatic collect_b(output b_chan_t b);
    b_ready = 1'b1;
    do @(negedge clk); while (!b_valid);
    b = b_o;
    @(posedge clk);
    #1;
    b_ready = 1'b0;
  endtask

  task automatic check_r(input r_chan_t r, input axi_id_t id, input per_data_t word,
                         input axi_resp_t resp);
    check(r.data === {word, word}, $sformatf("R data %h, expected %h", r.data, {word, word}));
    check(r.id === id && r.resp === resp && r.last === 1'b1,
          $sformatf("R id %0d resp %0d last %b, expected id %0d resp %0d last 1",
                    r.id, r.resp, r.last, id, resp));
  endtask

  task automatic check_b(input b_chan_t b, input axi_id_t id, input axi_resp_t resp);
    check(b.id === id && b.resp === resp,
          $sformatf("B id %0d resp %0d, expected id %0d resp %0d", b.id, b.resp, id, resp));
  endtask

  task automatic do_write(input axi_addr_t addr, input axi_id_t id, input axi_data_t data,
                          input axi_strb_t strb, input axi_resp_t resp);
    b_chan_t b;
    drive_write(addr, id, data, strb);
    wait_write_accept();
    collect_b(b);
    check_b(b, id, resp);
  endtask

  task automatic do_read(input axi_addr_t addr, input axi_id_t id, input per_data_t word,
                         input axi_resp_t resp);
    r_chan_t r;
    drive_read(addr, id);
    wait_read_accept();
    collect_r(r);
    check_r(r, id, word, resp);
  endtask

  task automatic test_write_read();
    cluster_id = '0;
    do_write(32'h10, 3'd1, {32'hffff_ffff, 32'h1234_5678}, 8'h0f, RESP_OKAY);
    do_read(32'h10, 3'd2, 32'h1234_5678, RESP_OKAY);
  endtask

  // Lower strobes are ignored for a write to the upper lane
  task automatic test_lane_select();
    per_data_t expected;
    do_write(32'h14, 3'd2, {32'h1122_3344, 32'hdead_beef}, 8'hf0, RESP_OKAY);
    do_write(32'h14, 3'd3, {32'haabb_ccdd, 32'hdead_beef}, 8'h5f, RESP_OKAY);
    expected = merge_bytes(32'h1122_3344, 32'haabb_ccdd, 4'b0101);
    do_read(32'h14, 3'd4, expected, RESP_OKAY);
  endtask

  // Cluster 1 starts at 0x0040_0000 in the global map
  task automatic test_cluster_offset();
    cluster_id = 6'd1;
    do_write(32'h0040_0020, 3'd1, {32'h0, 32'hcafe_f00d}, 8'h0f, RESP_OKAY);
    check(granted_write_add === 32'h20,
          $sformatf("Peripheral address %h, expected %h", granted_write_add, 32'h20));
    cluster_id = 6'd0;
    do_read(32'h20, 3'd2, 32'hcafe_f00d, RESP_OKAY);
  endtask

  task automatic test_read_priority();
    r_chan_t r;
    b_chan_t b;
    drive_write(32'h18, 3'd5, {32'h0, 32'h5555_aaaa}, 8'h0f);
    drive_read(32'h10, 3'd6);
    // The first grant goes to the read
    do @(negedge clk); while (!ar_ready && !aw_ready);
    check(ar_ready && !aw_ready, "Write was accepted ahead of the competing read");
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
    collect_r(r);
    check_r(r, 3'd6, 32'h1234_5678, RESP_OKAY);
    wait_write_accept();
    collect_b(b);
    check_b(b, 3'd5, RESP_OKAY);
    do_read(32'h18, 3'd7, 32'h5555_aaaa, RESP_OKAY);
  endtask

  task automatic test_back_pressure();
    r_chan_t held;
    r_chan_t r;
    drive_read(32'h10, 3'd3);
    wait_read_accept();
    do @(negedge clk); while (!r_valid);
    held = r_o;
    @(posedge clk);
    #1;
    drive_read(32'h10, 3'd4);
    repeat (4) begin
      @(negedge clk);
      check(r_valid && r_o === held, "R beat changed while r_ready was low");
      check(!ar_ready && busy, "Second read accepted while the first R beat was held");
    end
    @(posedge clk);
    #1;
    collect_r(r);
    check_r(r, 3'd3, 32'h1234_5678, RESP_OKAY);
    wait_read_accept();
    collect_r(r);
    check_r(r, 3'd4, 32'h1234_5678, RESP_OKAY);
  endtask

  // Bit 12 selects the error region of the target
  task automatic test_error_response();
    do_write(32'h1008, 3'd1, {2{32'h0bad_0bad}}, 8'hff, RESP_SLVERR);
    do_read(32'h1008, 3'd2, 32'h0, RESP_SLVERR);
  endtask

  initial begin
    #((TEST_CYCLES + RESET_CYCLES) * 40);
    $display("Run timed out: the DUT stopped answering before the tests completed");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hc3a1));
    rst_n      = 1'b0;
    cluster_id = '0;
    aw_valid   = 1'b0;
    ar_valid   = 1'b0;
    w_valid    = 1'b0;
    r_ready    = 1'b0;
    b_ready    = 1'b0;
    aw         = '0;
    ar         = '0;
    w          = '0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check(!per_req && !aw_ready && !ar_ready && !w_ready && !r_valid && !b_valid && !busy,
          "Outputs not low during reset");
    @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_write_read();
    test_lane_select();
    test_cluster_offset();
    test_read_priority();
    test_back_pressure();
    test_error_response();

    $display("Checks failed: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* testbench/per_slave_model.sv */
// Peripheral target model

`timescale 1ns/100ps

module per_slave_model
  import axi2per_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  per_req_t  req_data_i,
  output logic      gnt_o,
  output logic      r_valid_o,
  output per_resp_t resp_o
);

  per_data_t  mem [256];
  logic [1:0] delay_q;
  logic [1:0] wait_q;
  logic [7:0] idx;
  logic       err_region;

  assign idx        = req_data_i.add[9:2];
  assign err_region = req_data_i.add[12];

  // Grant once the drawn number of wait cycles has passed
  assign gnt_o = req_i && (wait_q == delay_q);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_q   <= '0;
      wait_q    <= '0;
      r_valid_o <= 1'b0;
      resp_o    <= '0;
      for (int i = 0; i < 256; i++) begin
        mem[i] <= 32'hc0de_0000 | 32'(i);
      end
    end else begin
      // Response follows the grant by one cycle
      r_valid_o <= gnt_o;
      if (gnt_o) begin
        wait_q       <= '0;
        delay_q      <= 2'($urandom % 4);
        resp_o.opc   <= err_region;
        resp_o.rdata <= (err_region || !req_data_i.we) ? '0 : mem[idx];
        // Writes into the error region are dropped
        if (!req_data_i.we && !err_region) begin
          for (int b = 0; b < 4; b++) begin
            if (req_data_i.be[b]) begin
              mem[idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
            end
          end
        end
      end else if (req_i) begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

endmodule
